// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_l2_cache
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== design/l2_addr_path.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_addr_path (
	input  wire                        clk,
	input  wire                        rst,
	input  wire [l2_pkg::addr_w-1:0]   i_addr,
	input  wire [l2_pkg::addr_w-1:0]   d_addr,
	input  wire [l2_pkg::addr_w-1:0]   c_addr,
	input  wire l2_pkg::ctrl_word_t    ctrl,
	input  wire l2_pkg::tag_entry_t    victim,
	output logic [l2_pkg::index_w-1:0] index,
	output logic [l2_pkg::tag_w-1:0]   req_tag,
	output logic [l2_pkg::addr_w-1:0]  mem_addr,
	output l2_pkg::tag_entry_t         c_tag_out
);

	logic [l2_pkg::addr_w-1:0] req_addr;

	////////////////////////////////////////////////////////////
	// requester address
	////////////////////////////////////////////////////////////
	always_comb begin
		if (ctrl.use_cop_index)
			req_addr = c_addr;
		else if (ctrl.addr_sel)
			req_addr = i_addr;
		else
			req_addr = d_addr;
	end

	assign index   = req_addr[l2_pkg::index_w-1:0];
	assign req_tag = req_addr[l2_pkg::addr_w-1:l2_pkg::index_w];

	// writeback goes to the victim's own address
	assign mem_addr = ctrl.mem_addr_sel ? {victim.tag, index} : req_addr;

	////////////////////////////////////////////////////////////
	// index load tag result
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (rst)
			c_tag_out <= '0;
		else if (ctrl.tag_cap)
			c_tag_out <= victim; // holds until next index load
	end

endmodule

`default_nettype wire

// ==== design/l2_cache_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_cache_ctrl (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  i_req,
	input  wire l2_pkg::d_op_e   d_op,
	input  wire l2_pkg::cache_op_e c_op,
	input  wire l2_pkg::line_status_t status,
	input  wire                  mem_ready,
	output l2_pkg::ctrl_word_t   ctrl,
	output logic                 mem_r,
	output logic                 mem_w,
	output logic                 i_ready,
	output logic                 d_ready,
	output logic                 c_ready
);

	l2_pkg::ctrl_state_e state_q, state_d;
	logic wb_needed; // miss on a dirty valid line
	logic d_is_write;

	assign wb_needed  = !status.hit && status.valid && status.dirty;
	assign d_is_write = (d_op == l2_pkg::d_write);

	// allocate a valid line with the request tag and dirty on a write
	function automatic l2_pkg::ctrl_word_t fill_line(input logic is_write);
		l2_pkg::ctrl_word_t w;
		w             = '0;
		w.valid_wdata = 1'b1;
		w.valid_we    = 1'b1;
		w.dirty_wdata = is_write;
		w.dirty_we    = 1'b1;
		w.tag_we      = 1'b1;
		w.data_we     = is_write; // fetched word is already in the array
		return w;
	endfunction

	always_ff @(posedge clk) begin
		if (rst)
			state_q <= l2_pkg::st_init;
		else
			state_q <= state_d;
	end

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////
	always_comb begin
		state_d = state_q;
		case (state_q)
			l2_pkg::st_init: state_d = l2_pkg::st_decode;
			l2_pkg::st_decode: begin
				if (c_op != l2_pkg::c_none) // maintenance before instruction before data
					state_d = l2_pkg::st_op;
				else if (i_req)
					state_d = l2_pkg::st_iop;
				else if (d_op != l2_pkg::d_none)
					state_d = l2_pkg::st_dop;
				else
					state_d = l2_pkg::st_init;
			end
			l2_pkg::st_op: begin
				if (c_op == l2_pkg::c_hit_writeback && status.hit && status.dirty && !mem_ready)
					state_d = l2_pkg::st_hit_wb;
				else
					state_d = l2_pkg::st_init;
			end
			l2_pkg::st_hit_wb: if (mem_ready) state_d = l2_pkg::st_init;
			l2_pkg::st_iop: begin
				if (status.hit)
					state_d = l2_pkg::st_init;
				else if (wb_needed)
					state_d = mem_ready ? l2_pkg::st_ifetch : l2_pkg::st_iwb;
				else
					state_d = mem_ready ? l2_pkg::st_istore : l2_pkg::st_ifetch;
			end
			l2_pkg::st_iwb:    if (mem_ready) state_d = l2_pkg::st_ifetch;
			l2_pkg::st_ifetch: if (mem_ready) state_d = l2_pkg::st_istore;
			l2_pkg::st_istore: state_d = l2_pkg::st_init;
			l2_pkg::st_dop: begin
				if (d_is_write)
					state_d = !wb_needed ? l2_pkg::st_init
						: (mem_ready ? l2_pkg::st_dstore : l2_pkg::st_dwb);
				else if (status.hit)
					state_d = l2_pkg::st_init;
				else if (wb_needed)
					state_d = mem_ready ? l2_pkg::st_dfetch : l2_pkg::st_dwb;
				else
					state_d = mem_ready ? l2_pkg::st_dstore : l2_pkg::st_dfetch;
			end
			l2_pkg::st_dwb: begin
				if (mem_ready) // write miss skips the fetch
					state_d = d_is_write ? l2_pkg::st_dstore : l2_pkg::st_dfetch;
			end
			l2_pkg::st_dfetch: if (mem_ready) state_d = l2_pkg::st_dstore;
			l2_pkg::st_dstore: state_d = l2_pkg::st_init;
			default:           state_d = l2_pkg::st_init;
		endcase
	end

	////////////////////////////////////////////////////////////
	// control word and handshakes
	////////////////////////////////////////////////////////////
	always_comb begin
		ctrl    = '0;
		mem_r   = 1'b0;
		mem_w   = 1'b0;
		i_ready = 1'b0;
		d_ready = 1'b0;
		c_ready = 1'b0;
		case (state_q)
			l2_pkg::st_decode: begin
				if (c_op != l2_pkg::c_none)
					ctrl.use_cop_index = 1'b1;
				else if (i_req)
					ctrl.addr_sel = 1'b1;
			end
			l2_pkg::st_op: begin
				ctrl.use_cop_index = 1'b1;
				case (c_op)
					l2_pkg::c_index_load_tag: begin
						ctrl.tag_cap = 1'b1;
						c_ready      = 1'b1;
					end
					l2_pkg::c_index_store_tag: begin
						ctrl.tag_src  = 1'b1; // whole entry from c_tag_in
						ctrl.tag_we   = 1'b1;
						ctrl.valid_we = 1'b1;
						ctrl.dirty_we = 1'b1;
						c_ready       = 1'b1;
					end
					l2_pkg::c_hit_writeback: begin
						if (status.hit && status.dirty) begin
							ctrl.mem_addr_sel = 1'b1;
							mem_w             = 1'b1;
							ctrl.dirty_we     = mem_ready; // clear dirty
							c_ready           = mem_ready;
						end else begin
							c_ready = 1'b1; // nothing to write
						end
					end
					default: ;
				endcase
			end
			l2_pkg::st_hit_wb: begin
				ctrl.use_cop_index = 1'b1;
				ctrl.mem_addr_sel  = 1'b1;
				mem_w              = 1'b1;
				ctrl.dirty_we      = mem_ready;
				c_ready            = mem_ready;
			end
			l2_pkg::st_iop: begin
				ctrl.addr_sel = 1'b1;
				if (status.hit) begin
					i_ready = 1'b1;
				end else if (wb_needed) begin
					ctrl.mem_addr_sel = 1'b1;
					mem_w             = 1'b1;
				end else begin
					mem_r         = 1'b1;
					ctrl.data_src = 1'b1;
					ctrl.data_we  = mem_ready; // early ready takes the word now
				end
			end
			l2_pkg::st_iwb: begin
				ctrl.addr_sel     = 1'b1;
				ctrl.mem_addr_sel = 1'b1;
				mem_w             = 1'b1;
			end
			l2_pkg::st_ifetch: begin
				ctrl.addr_sel = 1'b1;
				mem_r         = 1'b1;
				ctrl.data_src = 1'b1;
				ctrl.data_we  = mem_ready;
			end
			l2_pkg::st_istore: begin
				ctrl          = fill_line(1'b0);
				ctrl.addr_sel = 1'b1;
				i_ready       = 1'b1;
			end
			l2_pkg::st_dop: begin
				if (d_is_write && wb_needed) begin
					ctrl.mem_addr_sel = 1'b1;
					mem_w             = 1'b1;
				end else if (d_is_write) begin
					ctrl    = fill_line(1'b1); // write hit or clean allocate
					d_ready = 1'b1;
				end else if (status.hit) begin
					d_ready = 1'b1;
				end else if (wb_needed) begin
					ctrl.mem_addr_sel = 1'b1;
					mem_w             = 1'b1;
				end else begin
					mem_r         = 1'b1;
					ctrl.data_src = 1'b1;
					ctrl.data_we  = mem_ready;
				end
			end
			l2_pkg::st_dwb: begin
				ctrl.mem_addr_sel = 1'b1;
				mem_w             = 1'b1;
			end
			l2_pkg::st_dfetch: begin
				mem_r         = 1'b1;
				ctrl.data_src = 1'b1;
				ctrl.data_we  = mem_ready;
			end
			l2_pkg::st_dstore: begin
				ctrl    = fill_line(d_is_write);
				d_ready = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/l2_cache_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_cache_top (
	input  wire                        clk,
	input  wire                        rst,
	// instruction port
	input  wire                        i_req,
	input  wire [l2_pkg::addr_w-1:0]   i_addr,
	output logic [l2_pkg::data_w-1:0]  i_rdata,
	output logic                       i_ready,
	// data port
	input  wire l2_pkg::d_op_e         d_op,
	input  wire [l2_pkg::addr_w-1:0]   d_addr,
	input  wire [l2_pkg::data_w-1:0]   d_wdata,
	output logic [l2_pkg::data_w-1:0]  d_rdata,
	output logic                       d_ready,
	// maintenance port
	input  wire l2_pkg::cache_op_e     c_op,
	input  wire [l2_pkg::addr_w-1:0]   c_addr,
	input  wire l2_pkg::tag_entry_t    c_tag_in,
	output l2_pkg::tag_entry_t         c_tag_out,
	output logic                       c_ready,
	// main memory
	output logic [l2_pkg::addr_w-1:0]  mem_addr,
	output logic [l2_pkg::data_w-1:0]  mem_wdata,
	input  wire [l2_pkg::data_w-1:0]   mem_rdata,
	output logic                       mem_r,
	output logic                       mem_w,
	input  wire                        mem_ready
);

	l2_pkg::ctrl_word_t          ctrl;
	l2_pkg::line_status_t        status;
	l2_pkg::tag_entry_t          entry;
	logic [l2_pkg::index_w-1:0]  index;
	logic [l2_pkg::tag_w-1:0]    req_tag;
	logic [l2_pkg::data_w-1:0]   rdata;

	assign i_rdata   = rdata;
	assign d_rdata   = rdata;
	assign mem_wdata = rdata; // writeback source is the array word

	l2_cache_ctrl i_l2_cache_ctrl (
		.clk       (clk),
		.rst       (rst),
		.i_req     (i_req),
		.d_op      (d_op),
		.c_op      (c_op),
		.status    (status),
		.mem_ready (mem_ready),
		.ctrl      (ctrl),
		.mem_r     (mem_r),
		.mem_w     (mem_w),
		.i_ready   (i_ready),
		.d_ready   (d_ready),
		.c_ready   (c_ready)
	);

	l2_tag_store i_l2_tag_store (
		.clk     (clk),
		.rst     (rst),
		.index   (index),
		.req_tag (req_tag),
		.cop_tag (c_tag_in),
		.ctrl    (ctrl),
		.status  (status),
		.entry   (entry)
	);

	l2_data_store i_l2_data_store (
		.clk       (clk),
		.index     (index),
		.cpu_wdata (d_wdata),
		.mem_rdata (mem_rdata),
		.ctrl      (ctrl),
		.rdata     (rdata)
	);

	l2_addr_path i_l2_addr_path (
		.clk       (clk),
		.rst       (rst),
		.i_addr    (i_addr),
		.d_addr    (d_addr),
		.c_addr    (c_addr),
		.ctrl      (ctrl),
		.victim    (entry),
		.index     (index),
		.req_tag   (req_tag),
		.mem_addr  (mem_addr),
		.c_tag_out (c_tag_out)
	);

endmodule

`default_nettype wire

// ==== design/l2_data_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_data_store (
	input  wire                        clk,
	input  wire [l2_pkg::index_w-1:0]  index,
	input  wire [l2_pkg::data_w-1:0]   cpu_wdata,
	input  wire [l2_pkg::data_w-1:0]   mem_rdata,
	input  wire l2_pkg::ctrl_word_t    ctrl,
	output logic [l2_pkg::data_w-1:0]  rdata
);

	logic [l2_pkg::data_w-1:0] data_q [l2_pkg::lines];

	always_ff @(posedge clk) begin
		if (ctrl.data_we)
			data_q[index] <= ctrl.data_src ? mem_rdata : cpu_wdata;
	end

	// memory data forwarded while a fetch is in progress
	assign rdata = ctrl.data_src ? mem_rdata : data_q[index];

endmodule

`default_nettype wire

// ==== design/l2_pkg.sv ====
`default_nettype none

package l2_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////
	localparam int addr_w  = 16; // word address
	localparam int data_w  = 32;
	localparam int index_w = 4;
	localparam int tag_w   = addr_w - index_w;
	localparam int lines   = 1 << index_w;

	typedef enum logic [1:0] {
		d_none  = 2'd0,
		d_read  = 2'd1,
		d_write = 2'd2
	} d_op_e;

	typedef enum logic [1:0] {
		c_none            = 2'd0,
		c_index_load_tag  = 2'd1,
		c_index_store_tag = 2'd2,
		c_hit_writeback   = 2'd3
	} cache_op_e;

	typedef enum logic [3:0] {
		st_init,
		st_decode,
		st_op,
		st_hit_wb,
		st_iop,
		st_iwb,
		st_ifetch,
		st_istore,
		st_dop,
		st_dwb,
		st_dfetch,
		st_dstore
	} ctrl_state_e;

	typedef struct packed {
		logic             valid;
		logic             dirty;
		logic [tag_w-1:0] tag;
	} tag_entry_t;

	// commands from the controller to the datapath
	typedef struct packed {
		logic addr_sel;      // 1 = instruction address
		logic mem_addr_sel;  // 1 = victim tag for a writeback
		logic valid_wdata;
		logic valid_we;
		logic dirty_wdata;
		logic dirty_we;
		logic tag_src;       // 1 = maintenance tag input
		logic tag_we;
		logic data_src;      // 1 = memory read data
		logic data_we;
		logic tag_cap;       // index load capture
		logic use_cop_index; // address from maintenance port
	} ctrl_word_t;

	typedef struct packed {
		logic hit;
		logic valid;
		logic dirty;
	} line_status_t;

endpackage

`default_nettype wire

// ==== design/l2_tag_store.sv ====
`timescale 1ns/10ps
`default_nettype none

module l2_tag_store (
	input  wire                              clk,
	input  wire                              rst,
	input  wire [l2_pkg::index_w-1:0]        index,
	input  wire [l2_pkg::tag_w-1:0]          req_tag,
	input  wire l2_pkg::tag_entry_t          cop_tag,
	input  wire l2_pkg::ctrl_word_t          ctrl,
	output l2_pkg::line_status_t             status,
	output l2_pkg::tag_entry_t               entry
);

	logic [l2_pkg::lines-1:0] valid_q;
	logic [l2_pkg::lines-1:0] dirty_q;
	logic [l2_pkg::tag_w-1:0] tag_q [l2_pkg::lines];

	// flag bits clear on reset
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			dirty_q <= '0;
		end else begin
			if (ctrl.valid_we)
				valid_q[index] <= ctrl.tag_src ? cop_tag.valid : ctrl.valid_wdata;
			if (ctrl.dirty_we)
				dirty_q[index] <= ctrl.tag_src ? cop_tag.dirty : ctrl.dirty_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.tag_we)
			tag_q[index] <= ctrl.tag_src ? cop_tag.tag : req_tag;
	end

	always_comb begin
		entry.valid  = valid_q[index];
		entry.dirty  = dirty_q[index];
		entry.tag    = tag_q[index];
		status.hit   = entry.valid && (entry.tag == req_tag);
		status.valid = entry.valid;
		status.dirty = entry.dirty; // victim state on a miss
	end

endmodule

`default_nettype wire

// ==== tb.f ====
design/l2_pkg.sv
design/l2_tag_store.sv
design/l2_data_store.sv
design/l2_addr_path.sv
design/l2_cache_ctrl.sv
design/l2_cache_top.sv
testbench/tb_l2_cache.sv

// ==== testbench/l2_trace.txt ====
# op addr wdata_or_tag expected, all hex; op is ird drd dwr cst cld chw mem nrd nwr
# mem checks the memory word at addr, nrd and nwr check the memory read and write counts
nrd 0000 00000000 00000000
nwr 0000 00000000 00000000
ird 0010 00000000 5a5a0010
ird 0010 00000000 5a5a0010
nrd 0000 00000000 00000001
dwr 0023 cafe0001 00000000
drd 0023 00000000 cafe0001
nrd 0000 00000000 00000001
nwr 0000 00000000 00000000
drd 0045 00000000 5a5a0045
drd 0045 00000000 5a5a0045
nrd 0000 00000000 00000002
drd 0133 00000000 5a5a0133
nwr 0000 00000000 00000001
nrd 0000 00000000 00000003
mem 0023 00000000 cafe0001
ird 0133 00000000 5a5a0133
nrd 0000 00000000 00000003
dwr 0057 11110057 00000000
dwr 0157 22220157 00000000
nwr 0000 00000000 00000002
mem 0057 00000000 11110057
drd 0157 00000000 22220157
nrd 0000 00000000 00000003
cst 0008 000020ab 00000000
cst 0009 00001123 00000000
cld 0008 00000000 000020ab
cld 0009 00000000 00001123
cld 0010 00000000 00002001
cld 0133 00000000 00002013
chw 0157 00000000 00000000
nwr 0000 00000000 00000003
mem 0157 00000000 22220157
cld 0157 00000000 00002015
chw 0157 00000000 00000000
chw 0045 00000000 00000000
chw 0345 00000000 00000000
nwr 0000 00000000 00000003
drd 0257 00000000 5a5a0257
nwr 0000 00000000 00000003
nrd 0000 00000000 00000004

// ==== testbench/tb_l2_cache.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_l2_cache;

	localparam int ready_timeout = 200; // cycles per ready wait

	logic                          clk;
	logic                          rst;
	logic                          i_req;
	logic [l2_pkg::addr_w-1:0]     i_addr;
	logic [l2_pkg::data_w-1:0]     i_rdata;
	logic                          i_ready;
	l2_pkg::d_op_e                 d_op;
	logic [l2_pkg::addr_w-1:0]     d_addr;
	logic [l2_pkg::data_w-1:0]     d_wdata;
	logic [l2_pkg::data_w-1:0]     d_rdata;
	logic                          d_ready;
	l2_pkg::cache_op_e             c_op;
	logic [l2_pkg::addr_w-1:0]     c_addr;
	l2_pkg::tag_entry_t            c_tag_in;
	l2_pkg::tag_entry_t            c_tag_out;
	logic                          c_ready;
	logic [l2_pkg::addr_w-1:0]     mem_addr;
	logic [l2_pkg::data_w-1:0]     mem_wdata;
	logic [l2_pkg::data_w-1:0]     mem_rdata;
	logic                          mem_r;
	logic                          mem_w;
	logic                          mem_ready;

	// main memory model
	logic [l2_pkg::data_w-1:0] mem_q [0:65535];
	logic                      mem_busy;
	logic [1:0]                mem_delay;
	logic [31:0]               rand_state;
	int                        rd_count;
	int                        wr_count;
	int                        fd;

	l2_cache_top i_l2_cache_top (
		.clk       (clk),
		.rst       (rst),
		.i_req     (i_req),
		.i_addr    (i_addr),
		.i_rdata   (i_rdata),
		.i_ready   (i_ready),
		.d_op      (d_op),
		.d_addr    (d_addr),
		.d_wdata   (d_wdata),
		.d_rdata   (d_rdata),
		.d_ready   (d_ready),
		.c_op      (c_op),
		.c_addr    (c_addr),
		.c_tag_in  (c_tag_in),
		.c_tag_out (c_tag_out),
		.c_ready   (c_ready),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata),
		.mem_r     (mem_r),
		.mem_w     (mem_w),
		.mem_ready (mem_ready)
	);

	always #4 clk = ~clk;

	function automatic logic [31:0] next_random(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	////////////////////////////////////////////////////////////
	// memory model
	////////////////////////////////////////////////////////////
	always @(negedge clk) begin
		if (rst || mem_ready) begin
			mem_ready = 1'b0; // transfer taken at the last rising edge
			mem_busy  = 1'b0;
		end else if (mem_r || mem_w) begin
			if (!mem_busy) begin
				mem_busy   = 1'b1;
				rand_state = next_random(rand_state);
				mem_delay  = rand_state[17:16]; // 0 to 3 wait cycles
			end
			if (mem_delay == 2'd0) begin
				mem_ready = 1'b1;
				mem_rdata = mem_q[mem_addr];
			end else begin
				mem_delay = mem_delay - 2'd1;
			end
		end
	end

	always @(posedge clk) begin
		if (mem_ready && mem_w) begin
			mem_q[mem_addr] = mem_wdata;
			wr_count++;
		end
		if (mem_ready && mem_r)
			rd_count++;
	end

	////////////////////////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////////////////////////
	task automatic abort_run(input string reason);
		$display("SIMULATION FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_data(input string name, input logic [l2_pkg::data_w-1:0] expected,
			input logic [l2_pkg::data_w-1:0] actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			abort_run("wrong data word");
		end
	endtask

	task automatic check_tag(input string name, input l2_pkg::tag_entry_t expected,
			input l2_pkg::tag_entry_t actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			abort_run("wrong tag entry");
		end
	endtask

	task automatic check_count(input string name, input int expected, input int actual);
		if (actual != expected) begin
			$display("Mismatch %s: expected %0d, actual %0d", name, expected, actual);
			abort_run("wrong memory access count");
		end
	endtask

	task automatic check_flags(input string name, input logic [4:0] expected,
			input logic [4:0] actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %b, actual %b", name, expected, actual);
			abort_run("wrong handshake outputs");
		end
	endtask

	////////////////////////////////////////////////////////////
	// requester tasks
	////////////////////////////////////////////////////////////
	// port 0 instruction, 1 data, 2 maintenance
	task automatic wait_ready(input int port, input string name,
			output logic [l2_pkg::data_w-1:0] rdata);
		int   cycles;
		logic done;
		cycles = 0;
		done   = 1'b0;
		rdata  = '0;
		while (!done && cycles < ready_timeout) begin
			@(posedge clk);
			cycles++;
			done  = (port == 0) ? i_ready : (port == 1) ? d_ready : c_ready;
			rdata = (port == 0) ? i_rdata : d_rdata; // valid only in the ready cycle
		end
		if (!done) begin
			$display("Timeout: %s got no ready pulse within %0d cycles", name, ready_timeout);
			abort_run("ready wait timed out");
		end
	endtask

	task automatic inst_read(input logic [l2_pkg::addr_w-1:0] addr, input string name,
			output logic [l2_pkg::data_w-1:0] rdata);
		@(negedge clk);
		i_req  = 1'b1;
		i_addr = addr;
		wait_ready(0, name, rdata);
		@(negedge clk);
		i_req = 1'b0; // dropped before the next decode
	endtask

	task automatic data_access(input l2_pkg::d_op_e op, input logic [l2_pkg::addr_w-1:0] addr,
			input logic [l2_pkg::data_w-1:0] wdata, input string name,
			output logic [l2_pkg::data_w-1:0] rdata);
		@(negedge clk);
		d_op    = op;
		d_addr  = addr;
		d_wdata = wdata;
		wait_ready(1, name, rdata);
		@(negedge clk);
		d_op = l2_pkg::d_none;
	endtask

	task automatic maint_access(input l2_pkg::cache_op_e op,
			input logic [l2_pkg::addr_w-1:0] addr, input l2_pkg::tag_entry_t tag,
			input string name);
		logic [l2_pkg::data_w-1:0] ignored;
		@(negedge clk);
		c_op     = op;
		c_addr   = addr;
		c_tag_in = tag;
		wait_ready(2, name, ignored);
		@(negedge clk);
		c_op = l2_pkg::c_none;
	endtask

	////////////////////////////////////////////////////////////
	// trace player
	////////////////////////////////////////////////////////////
	task automatic run_trace(input int fd);
		logic [8*160-1:0]          line_buf;
		logic [23:0]               op;
		logic [l2_pkg::addr_w-1:0] addr;
		logic [31:0]               arg;
		logic [31:0]               expected;
		logic [l2_pkg::data_w-1:0] rdata;
		l2_pkg::tag_entry_t        tag;
		int                        fields;
		int                        line_no;
		string                     name;
		line_no = 0;
		while (!$feof(fd)) begin
			line_buf = '0;
			op       = '0;
			if ($fgets(line_buf, fd) != 0) begin
				line_no++;
				fields = $sscanf(line_buf, "%s %h %h %h", op, addr, arg, expected);
				name   = $sformatf("line %0d %s %h", line_no, op, addr);
				tag    = l2_pkg::tag_entry_t'(arg[$bits(l2_pkg::tag_entry_t)-1:0]);
				if (fields >= 1 && op == {16'h0, "#"}) begin
					// comment line
				end else if (fields == 4) begin
					case (op)
						"ird": begin
							inst_read(addr, name, rdata);
							check_data(name, expected, rdata);
						end
						"drd": begin
							data_access(l2_pkg::d_read, addr, '0, name, rdata);
							check_data(name, expected, rdata);
						end
						"dwr": data_access(l2_pkg::d_write, addr, arg, name, rdata);
						"cst": maint_access(l2_pkg::c_index_store_tag, addr, tag, name);
						"cld": begin
							maint_access(l2_pkg::c_index_load_tag, addr, '0, name);
							check_tag(name, l2_pkg::tag_entry_t'(
								expected[$bits(l2_pkg::tag_entry_t)-1:0]), c_tag_out);
						end
						"chw": maint_access(l2_pkg::c_hit_writeback, addr, '0, name);
						"mem": check_data(name, expected, mem_q[addr]);
						"nrd": check_count(name, int'(expected), rd_count);
						"nwr": check_count(name, int'(expected), wr_count);
						default: begin
							$display("Unknown operation on trace line %0d", line_no);
							abort_run("bad trace operation");
						end
					endcase
				end else if (fields > 0) begin
					$display("Trace line %0d does not have four fields", line_no);
					abort_run("malformed trace line");
				end
			end
		end
	endtask

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		i_req      = 1'b0;
		i_addr     = '0;
		d_op       = l2_pkg::d_none;
		d_addr     = '0;
		d_wdata    = '0;
		c_op       = l2_pkg::c_none;
		c_addr     = '0;
		c_tag_in   = '0;
		mem_rdata  = '0;
		mem_ready  = 1'b0;
		mem_busy   = 1'b0;
		mem_delay  = 2'd0;
		rand_state = 32'ha8b0;
		rd_count   = 0;
		wr_count   = 0;
		for (int a = 0; a < 65536; a++)
			mem_q[a[15:0]] = {16'h0, a[15:0]} ^ 32'h5a5a0000; // address xor a fixed pattern
		repeat (8) @(negedge clk);
		check_flags("reset outputs", 5'b0, {i_ready, d_ready, c_ready, mem_r, mem_w});
		rst = 1'b0;
		fd  = $fopen("testbench/l2_trace.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the trace file testbench/l2_trace.txt");
			abort_run("trace file missing");
		end else begin
			run_trace(fd);
			$fclose(fd);
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire
